//--- filelist.f
verilog/organ_pkg.sv
verilog/tone_generator.sv
verilog/key_conditioner.sv
verilog/speed_control.sv
verilog/hex_display.sv
verilog/basic_organ.sv
tb/tb_basic_organ.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, result taken from the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module tb_basic_organ -f filelist.f -o tb_basic_organ > "$LOG" 2>&1 \
  && ./obj_dir/tb_basic_organ >> "$LOG" 2>&1 \
  || { cat "$LOG"; echo "Build or simulation error"; exit 1; }
cat "$LOG"
grep -q "Simulation FAILED" "$LOG" && { echo "Test failed"; exit 1; }
grep -q "Simulation PASSED" "$LOG" || { echo "No result found in log"; exit 1; }
exit 0

//--- tb/tb_basic_organ.sv
`timescale 1ns/1ps
`default_nettype none

module tb_basic_organ;

  localparam int REPEAT_DIV  = 64;
  localparam int REFRESH_DIV = 32;
  localparam logic [15:0] DEFAULT_COUNT = 16'd12499;

  // ==============================
  // Stimulus and expected values
  // ==============================

  // Label and level length (half-period + 1) per switch code
  localparam logic [31:0] NOTE_LABEL [8] = '{
    " Do ", " Re ", " Mi ", " Fa ", " So ", " La ", " Ti ", "DO2 "
  };
  localparam int NOTE_LEN [8] = '{
    32'hBAB8, 32'hA65C, 32'h942F, 32'h8BE8, 32'h7CB7, 32'h6EF8, 32'h62F0, 32'h5D5C
  };

  // Per key row the key_n pattern, hold in repeat ticks and expected sample_count
  localparam int KEY_ROWS = 6;
  localparam logic [2:0] KEY_PAT [KEY_ROWS] = '{
    3'b110, 3'b101, 3'b011, 3'b101, 3'b110, 3'b011
  };
  localparam int KEY_TICKS [KEY_ROWS] = '{3, 5, 0, 2, 1, 0};
  localparam logic [15:0] KEY_EXPECT [KEY_ROWS] = '{
    16'd12799, 16'd12299, 16'd12499, 16'd12299, 16'd12399, 16'd12499
  };

  // Active-low segments with bit 0 as segment a
  localparam logic [6:0] SEG_CODE [16] = '{
    7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
    7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E
  };

  logic        CLK_50M = 1'b0;
  logic        reset;
  logic [9:0]  sw;
  logic [2:0]  key_n;
  logic [7:0]  audio_sample;
  logic [31:0] note_label;
  logic [15:0] sample_count;
  logic [6:0]  hex_out [6];
  logic [31:0] lfsr_state = 32'h2ba6;
  int          mismatch_count = 0;
  int          failure_count = 0;
  int          cycle_count = 0;
  int          up_changes = 0;
  int          down_changes = 0;

  basic_organ #(
    .REPEAT_DIV  (REPEAT_DIV),
    .REFRESH_DIV (REFRESH_DIV)
  ) UUT (
    .CLK_50M      (CLK_50M),
    .reset        (reset),
    .sw           (sw),
    .key_n        (key_n),
    .audio_sample (audio_sample),
    .note_label   (note_label),
    .sample_count (sample_count),
    .hex0         (hex_out[0]),
    .hex1         (hex_out[1]),
    .hex2         (hex_out[2]),
    .hex3         (hex_out[3]),
    .hex4         (hex_out[4]),
    .hex5         (hex_out[5])
  );

  always #10 CLK_50M = ~CLK_50M;

  // Three levels per note, one muted period, key ticks and margin
  function automatic int run_limit();
    int total;
    int longest;
    total = 0;
    longest = 0;
    for (int i = 0; i < 8; i++)
    begin
      total = total + 3 * NOTE_LEN[i];
      if (NOTE_LEN[i] > longest)
        longest = NOTE_LEN[i];
    end
    return total + 2 * longest + 200 * REPEAT_DIV + 1000;
  endfunction

  always @(posedge CLK_50M)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= run_limit())
    begin
      $display("Timeout: run did not finish within %0d cycles", run_limit());
      failure_count = failure_count + 1;
      $display("Errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
      $display("Simulation FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  task automatic take_bits(input int n, output int value);
    value = 0;
    for (int k = 0; k < n; k++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      value = (value << 1) | int'(lfsr_state[0]);
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected)
    else
    begin
      $display("MISMATCH %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
      mismatch_count++;
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge CLK_50M);
  endtask

  // Upper two digits always show 0
  task automatic check_display(input string name, input logic [15:0] value);
    logic [3:0] nibble;
    for (int k = 0; k < 6; k++)
    begin
      nibble = (k < 4) ? value[4*k +: 4] : 4'h0;
      check_value($sformatf("%s hex%0d", name, k), 32'(SEG_CODE[nibble]), 32'(hex_out[k]));
    end
  endtask

  // ==============================
  // Tone and key sequences
  // ==============================

  task automatic play_note(input int code);
    logic [7:0] last;
    int         changes;
    int         span;
    string      name;
    name = $sformatf("note %0d", code);
    @(posedge CLK_50M);
    sw <= {6'b0, 3'(code), 1'b1};
    @(negedge CLK_50M);
    check_value({name, " label"}, NOTE_LABEL[code], note_label);
    last = audio_sample;
    changes = 0;
    span = 0;
    // First interval may straddle the note change
    while (changes < 3)
    begin
      @(negedge CLK_50M);
      span++;
      assert (audio_sample == 8'h7F || audio_sample == 8'h80)
      else
      begin
        $display("MISMATCH %s level: expected 0x7f or 0x80, actual 0x%0h", name, audio_sample);
        mismatch_count++;
      end
      if (audio_sample != last)
      begin
        changes++;
        if (changes == 3)
          check_value({name, " level length"}, NOTE_LEN[code], 32'(span));
        span = 0;
        last = audio_sample;
      end
    end
  endtask

  task automatic run_key_row(input int row);
    logic [15:0] last;
    logic [15:0] step;
    logic [15:0] next_count;
    logic [15:0] model;
    int          events;
    int          extra;
    int          waited;
    string       name;
    name = $sformatf("key row %0d", row);
    @(posedge CLK_50M);
    key_n <= KEY_PAT[row];
    if (!KEY_PAT[row][2])
    begin
      // Clear lands within four cycles
      waited = 0;
      @(negedge CLK_50M);
      while (sample_count != DEFAULT_COUNT && waited < 4)
      begin
        @(negedge CLK_50M);
        waited++;
      end
      check_value({name, " clear"}, 32'(DEFAULT_COUNT), 32'(sample_count));
      up_changes = 0;
      down_changes = 0;
    end
    else
    begin
      step = (KEY_PAT[row][0] == 1'b0) ? 16'd100 : 16'hFF9C;
      events = 0;
      @(negedge CLK_50M);
      last = sample_count;
      while (events < KEY_TICKS[row])
      begin
        @(negedge CLK_50M);
        if (sample_count != last)
        begin
          next_count = last + step;
          check_value({name, " step"}, 32'(next_count), 32'(sample_count));
          if (step == 16'd100)
            up_changes++;
          else
            down_changes++;
          events++;
          last = sample_count;
        end
      end
      // Hold on into the next repeat interval but short of its tick
      take_bits(5, extra);
      wait_cycles(extra);
    end
    @(posedge CLK_50M);
    key_n <= 3'b111;
    wait_cycles(REPEAT_DIV + 4);
    model = DEFAULT_COUNT + 16'(100 * (up_changes - down_changes));
    check_value({name, " table count"}, 32'(KEY_EXPECT[row]), 32'(sample_count));
    check_value({name, " observed count"}, 32'(model), 32'(sample_count));
    wait_cycles(REFRESH_DIV + 2);
    check_display(name, KEY_EXPECT[row]);
  endtask

  initial
  begin
    int order [8];
    int pick;
    int tmp;
    reset = 1'b1;
    sw = '0;
    key_n = 3'b111;
    repeat (4) @(posedge CLK_50M);
    reset <= 1'b0;
    @(negedge CLK_50M);
    check_value("reset sample_count", 32'(DEFAULT_COUNT), 32'(sample_count));
    check_value("reset audio_sample", 32'h80, 32'(audio_sample));
    wait_cycles(REFRESH_DIV + 2);
    check_display("reset display", 16'h30D3);

    // Shuffled note order
    for (int i = 0; i < 8; i++)
      order[i] = i;
    for (int i = 7; i > 0; i--)
    begin
      take_bits(3, pick);
      pick = pick % (i + 1);
      tmp = order[i];
      order[i] = order[pick];
      order[pick] = tmp;
    end
    for (int i = 0; i < 8; i++)
      play_note(order[i]);

    // Muted over a full period of the last note
    @(posedge CLK_50M);
    sw[0] <= 1'b0;
    wait_cycles(2);
    for (int i = 0; i < 2 * NOTE_LEN[order[7]] + 2; i++)
    begin
      @(negedge CLK_50M);
      check_value("audio muted", 32'h80, 32'(audio_sample));
    end

    for (int r = 0; r < KEY_ROWS; r++)
      run_key_row(r);

    $display("Errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
    if (mismatch_count == 0 && failure_count == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/basic_organ.sv
`timescale 1ns/1ps
`default_nettype none

module basic_organ
  import organ_pkg::*;
#(
  parameter int unsigned REPEAT_DIV  = 5000000,
  parameter int unsigned REFRESH_DIV = 25000000
) (
  input  logic          CLK_50M,
  input  logic          reset,
  input  logic [9:0]    sw,
  input  logic [2:0]    key_n,
  output audio_sample_t audio_sample,
  output logic [31:0]   note_label,
  output sample_count_t sample_count,
  output seg_t          hex0,
  output seg_t          hex1,
  output seg_t          hex2,
  output seg_t          hex3,
  output seg_t          hex4,
  output seg_t          hex5
);

  logic up_event;
  logic down_event;
  logic clear_level;

  // ==============================
  // Tone organ
  // ==============================

  // sw[0] enables the sound, sw[3:1] picks the note
  tone_generator u_tone_generator (
    .CLK_50M      (CLK_50M),
    .reset        (reset),
    .note         (note_e'(sw[3:1])),
    .audio_enable (sw[0]),
    .audio_sample (audio_sample),
    .note_label   (note_label)
  );

  // ==============================
  // Speed control and display
  // ==============================

  key_conditioner #(
    .REPEAT_DIV (REPEAT_DIV)
  ) u_key_conditioner (
    .CLK_50M     (CLK_50M),
    .reset       (reset),
    .key_n       (key_n),
    .up_event    (up_event),
    .down_event  (down_event),
    .clear_level (clear_level)
  );

  speed_control u_speed_control (
    .CLK_50M      (CLK_50M),
    .reset        (reset),
    .up_event     (up_event),
    .down_event   (down_event),
    .clear_level  (clear_level),
    .sample_count (sample_count)
  );

  hex_display #(
    .REFRESH_DIV (REFRESH_DIV)
  ) u_hex_display (
    .CLK_50M      (CLK_50M),
    .reset        (reset),
    .sample_count (sample_count),
    .hex0         (hex0),
    .hex1         (hex1),
    .hex2         (hex2),
    .hex3         (hex3),
    .hex4         (hex4),
    .hex5         (hex5)
  );

endmodule

`default_nettype wire

//--- verilog/hex_display.sv
`timescale 1ns/1ps
`default_nettype none

module hex_display
  import organ_pkg::*;
#(
  parameter int unsigned REFRESH_DIV = 25000000
) (
  input  logic          CLK_50M,
  input  logic          reset,
  input  sample_count_t sample_count,
  output seg_t          hex0,
  output seg_t          hex1,
  output seg_t          hex2,
  output seg_t          hex3,
  output seg_t          hex4,
  output seg_t          hex5
);

  localparam int CNT_W = (REFRESH_DIV > 1) ? $clog2(REFRESH_DIV) : 1;

  logic [CNT_W-1:0] refresh_count;
  logic             refresh_tick;
  logic [23:0]      display_value;
  seg_t             digit_seg [6];

  // Hex nibble to active-low segments
  function automatic seg_t seg_decode(input logic [3:0] nibble);
    case (nibble)
      4'h0: seg_decode = 7'h40;
      4'h1: seg_decode = 7'h79;
      4'h2: seg_decode = 7'h24;
      4'h3: seg_decode = 7'h30;
      4'h4: seg_decode = 7'h19;
      4'h5: seg_decode = 7'h12;
      4'h6: seg_decode = 7'h02;
      4'h7: seg_decode = 7'h78;
      4'h8: seg_decode = 7'h00;
      4'h9: seg_decode = 7'h10;
      4'hA: seg_decode = 7'h08;
      4'hB: seg_decode = 7'h03;
      4'hC: seg_decode = 7'h46;
      4'hD: seg_decode = 7'h21;
      4'hE: seg_decode = 7'h06;
      default: seg_decode = 7'h0E;
    endcase
  endfunction

  // ==============================
  // Slow refresh of the shown value
  // ==============================

  assign refresh_tick = (refresh_count == CNT_W'(REFRESH_DIV - 1));

  always_ff @(posedge CLK_50M)
  begin
    if (reset || refresh_tick)
      refresh_count <= '0;
    else
      refresh_count <= refresh_count + 1'b1;
  end

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
      display_value <= '0;
    else if (refresh_tick)
      display_value <= {8'h00, sample_count};
  end

  // One decoder per digit
  for (genvar i = 0; i < 6; i++)
  begin : g_digit
    assign digit_seg[i] = seg_decode(display_value[4*i +: 4]);
  end

  assign hex0 = digit_seg[0];
  assign hex1 = digit_seg[1];
  assign hex2 = digit_seg[2];
  assign hex3 = digit_seg[3];
  assign hex4 = digit_seg[4];
  assign hex5 = digit_seg[5];

endmodule

`default_nettype wire

//--- verilog/key_conditioner.sv
`timescale 1ns/1ps
`default_nettype none

module key_conditioner #(
  parameter int unsigned REPEAT_DIV = 5000000
) (
  input  logic       CLK_50M,
  input  logic       reset,
  input  logic [2:0] key_n,
  output logic       up_event,
  output logic       down_event,
  output logic       clear_level
);

  localparam int CNT_W = (REPEAT_DIV > 1) ? $clog2(REPEAT_DIV) : 1;

  logic [2:0]       key_meta;
  logic [2:0]       key_sync;
  logic [CNT_W-1:0] repeat_count;
  logic             repeat_tick;

  // ==============================
  // Key synchronizers
  // ==============================

  // Keys are active low, pressed reads as 1 after inversion
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      key_meta <= '0;
      key_sync <= '0;
    end
    else
    begin
      key_meta <= ~key_n;
      key_sync <= key_meta;
    end
  end

  assign clear_level = key_sync[2];

  // ==============================
  // Repeat-rate sampling
  // ==============================

  assign repeat_tick = (repeat_count == CNT_W'(REPEAT_DIV - 1));

  always_ff @(posedge CLK_50M)
  begin
    if (reset || repeat_tick)
      repeat_count <= '0;
    else
      repeat_count <= repeat_count + 1'b1;
  end

  // One event per tick while a key is held
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      up_event   <= 1'b0;
      down_event <= 1'b0;
    end
    else
    begin
      up_event   <= repeat_tick & key_sync[0];
      down_event <= repeat_tick & key_sync[1];
    end
  end

  a_up_single_cycle: assert property (@(posedge CLK_50M) disable iff (reset)
    up_event |=> !up_event)
    else $error("up_event held for more than one cycle");

endmodule

`default_nettype wire

//--- verilog/organ_pkg.sv
`default_nettype none

package organ_pkg;

  // ==============================
  // Notes and divider counts
  // ==============================

  // Encoding equals the switch code on sw[3:1]
  typedef enum logic [2:0] {
    do_523  = 3'd0,
    re_587  = 3'd1,
    mi_659  = 3'd2,
    fa_698  = 3'd3,
    so_783  = 3'd4,
    la_880  = 3'd5,
    ti_987  = 3'd6,
    do_1046 = 3'd7
  } note_e;

  typedef logic [31:0] half_period_t;

  // Half-period counts in CLK_50M cycles, indexed by note code
  localparam half_period_t note_half_period [8] = '{
    32'h0000_BAB7, 32'h0000_A65B, 32'h0000_942E, 32'h0000_8BE7,
    32'h0000_7CB6, 32'h0000_6EF7, 32'h0000_62EF, 32'h0000_5D5B
  };

  // ==============================
  // Label characters
  // ==============================

  typedef logic [7:0] ascii_t;

  localparam ascii_t ASCII_SPACE   = 8'h20;
  localparam ascii_t ASCII_TWO     = 8'h32;
  localparam ascii_t ASCII_D       = 8'h44;
  localparam ascii_t ASCII_F       = 8'h46;
  localparam ascii_t ASCII_L       = 8'h4C;
  localparam ascii_t ASCII_M       = 8'h4D;
  localparam ascii_t ASCII_O       = 8'h4F;
  localparam ascii_t ASCII_R       = 8'h52;
  localparam ascii_t ASCII_S       = 8'h53;
  localparam ascii_t ASCII_T       = 8'h54;
  localparam ascii_t ASCII_LOWER_A = 8'h61;
  localparam ascii_t ASCII_LOWER_E = 8'h65;
  localparam ascii_t ASCII_LOWER_I = 8'h69;
  localparam ascii_t ASCII_LOWER_O = 8'h6F;

  // ==============================
  // Audio, speed and display
  // ==============================

  typedef logic signed [7:0]  audio_sample_t;
  typedef logic signed [15:0] speed_t;
  typedef logic [15:0]        sample_count_t;

  // 2 kHz scope sampling at 50 MHz
  localparam sample_count_t DEFAULT_SAMPLE_COUNT = 16'd12499;
  localparam speed_t        SPEED_STEP           = 16'sd100;

  // Active low, bit 0 is segment a, bit 6 is segment g
  typedef logic [6:0] seg_t;

endpackage

`default_nettype wire

//--- verilog/speed_control.sv
`timescale 1ns/1ps
`default_nettype none

module speed_control
  import organ_pkg::*;
(
  input  logic          CLK_50M,
  input  logic          reset,
  input  logic          up_event,
  input  logic          down_event,
  input  logic          clear_level,
  output sample_count_t sample_count
);

  speed_t speed;

  // Clear wins over both step directions
  always_ff @(posedge CLK_50M)
  begin
    if (reset || clear_level)
      speed <= '0;
    else if (up_event)
      speed <= speed + SPEED_STEP;
    else if (down_event)
      speed <= speed - SPEED_STEP;
  end

  // Sampling count offset from the 2 kHz default
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
      sample_count <= DEFAULT_SAMPLE_COUNT;
    else
      sample_count <= DEFAULT_SAMPLE_COUNT + sample_count_t'(speed);
  end

  a_speed_step: assert property (@(posedge CLK_50M) disable iff (reset)
    !clear_level |=> ((speed == $past(speed))
                   || (speed == speed_t'($past(speed) + SPEED_STEP))
                   || (speed == speed_t'($past(speed) - SPEED_STEP))))
    else $error("speed changed by more than one step");

endmodule

`default_nettype wire

//--- verilog/tone_generator.sv
`timescale 1ns/1ps
`default_nettype none

module tone_generator
  import organ_pkg::*;
(
  input  logic          CLK_50M,
  input  logic          reset,
  input  note_e         note,
  input  logic          audio_enable,
  output audio_sample_t audio_sample,
  output logic [31:0]   note_label
);

  half_period_t half_period;
  half_period_t div_count;
  note_e        note_q;
  logic         tone_level;

  assign half_period = note_half_period[note];

  // ==============================
  // Square-wave divider
  // ==============================

  // Each level lasts half_period+1 cycles
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      div_count  <= '0;
      note_q     <= do_523;
      tone_level <= 1'b0;
    end
    else
    begin
      note_q <= note;
      if (note != note_q)
        // New note restarts the count, level is kept
        div_count <= '0;
      else if (div_count >= half_period)
      begin
        div_count  <= '0;
        tone_level <= ~tone_level;
      end
      else
        div_count <= div_count + 1'b1;
    end
  end

  // Signed full-scale swing when enabled
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
      audio_sample <= 8'sh80;
    else if (audio_enable && tone_level)
      audio_sample <= 8'sh7F;
    else
      audio_sample <= 8'sh80;
  end

  // Note name, first character in the top byte
  always_comb
  begin
    case (note)
      do_523:  note_label = {ASCII_SPACE, ASCII_D, ASCII_LOWER_O, ASCII_SPACE};
      re_587:  note_label = {ASCII_SPACE, ASCII_R, ASCII_LOWER_E, ASCII_SPACE};
      mi_659:  note_label = {ASCII_SPACE, ASCII_M, ASCII_LOWER_I, ASCII_SPACE};
      fa_698:  note_label = {ASCII_SPACE, ASCII_F, ASCII_LOWER_A, ASCII_SPACE};
      so_783:  note_label = {ASCII_SPACE, ASCII_S, ASCII_LOWER_O, ASCII_SPACE};
      la_880:  note_label = {ASCII_SPACE, ASCII_L, ASCII_LOWER_A, ASCII_SPACE};
      ti_987:  note_label = {ASCII_SPACE, ASCII_T, ASCII_LOWER_I, ASCII_SPACE};
      default: note_label = {ASCII_D, ASCII_O, ASCII_TWO, ASCII_SPACE};
    endcase
  end

  // Counter stays within the count of the note it runs on
  a_div_count_range: assert property (@(posedge CLK_50M) disable iff (reset)
    div_count <= note_half_period[note_q])
    else $error("divider count exceeds the note half-period");

endmodule

`default_nettype wire
